/* verilog/mem_pkg.sv */
package mem_pkg;

    // One data or instruction word on the shared bus
    typedef logic [31:0] word_t;

    // Byte address; only word-aligned values reach the bus
    typedef logic [31:0] addr_t;

endpackage

/* verilog/riscv_pkg.sv */
package riscv_pkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // Branch conditions
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // Full EBREAK encoding, seen by the fetcher
    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

    // Register file index
    typedef logic [4:0] reg_idx_t;

    // Execute stage FSM
    typedef enum logic [1:0] {
        EXEC,
        WAIT_MEM,
        HALT
    } core_state_t;

endpackage

/* verilog/fetcher.sv */
`timescale 1ns/1ps

module fetcher (
    input  logic           CLK,
    input  logic           rst_n,
    input  mem_pkg::addr_t pc,
    input  logic           redirect,
    input  logic           instr_take,
    input  logic           f_ack,
    input  mem_pkg::word_t f_rdata,
    output mem_pkg::word_t instr,
    output logic           instr_valid,
    output logic           f_req,
    output mem_pkg::addr_t f_addr
);

    logic           busy;
    logic           discard;
    logic           parked;
    logic           ebreak_take;
    logic           start;
    mem_pkg::addr_t start_addr;

    // No prefetch past EBREAK, bus goes quiet after halt
    assign ebreak_take = instr_take && (instr == riscv_pkg::INSTR_EBREAK);
    assign start = !busy && !parked && !ebreak_take && (!instr_valid || instr_take);

    // Buffer holds the word at pc, so guess the next sequential one on a take
    assign start_addr = instr_take ? pc + 32'd4 : pc;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            f_req       <= 1'b0;
            busy        <= 1'b0;
            discard     <= 1'b0;
            parked      <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            if (ebreak_take) begin
                parked <= 1'b1;
            end
            if (instr_take) begin
                instr_valid <= 1'b0;
            end
            if (start) begin
                f_req   <= 1'b1;
                busy    <= 1'b1;
                // Branch taken now makes the guessed address stale
                discard <= redirect;
            end else begin
                if (redirect && busy) begin
                    discard <= 1'b1;
                end
                if (f_req && f_ack) begin
                    f_req <= 1'b0;
                end else if (busy && !f_req && !f_ack) begin
                    // Return to zero done
                    busy        <= 1'b0;
                    instr_valid <= !discard;
                    discard     <= 1'b0;
                end
            end
        end
    end

    // Address and read data
    always_ff @(posedge CLK) begin
        if (start) begin
            f_addr <= start_addr;
        end
        if (f_req && f_ack) begin
            instr <= f_rdata;
        end
    end

    // Core may only consume a filled buffer
    a_take_valid: assert property (@(posedge CLK) disable iff (!rst_n)
        instr_take |-> instr_valid);

endmodule

/* verilog/lsu.sv */
`timescale 1ns/1ps

module lsu (
    input  logic           CLK,
    input  logic           rst_n,
    input  logic           cmd_start,
    input  logic           cmd_we,
    input  mem_pkg::addr_t cmd_addr,
    input  mem_pkg::word_t cmd_wdata,
    input  logic           d_ack,
    input  mem_pkg::word_t d_rdata,
    output logic           done,
    output mem_pkg::word_t load_data,
    output logic           d_req,
    output logic           d_we,
    output mem_pkg::addr_t d_addr,
    output mem_pkg::word_t d_wdata
);

    // High from command until ack has returned low
    logic busy;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            d_req <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (cmd_start) begin
                d_req <= 1'b1;
                busy  <= 1'b1;
            end else if (d_req && d_ack) begin
                d_req <= 1'b0;
            end else if (busy && !d_req && !d_ack) begin
                // Slave released ack
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // Command latch, held through the whole handshake
    always_ff @(posedge CLK) begin
        if (cmd_start) begin
            d_we    <= cmd_we;
            d_addr  <= cmd_addr;
            d_wdata <= cmd_wdata;
        end
        // rdata only valid while ack is high
        if (d_req && d_ack) begin
            load_data <= d_rdata;
        end
    end

    // Core must wait for done before the next command
    a_no_overlap: assert property (@(posedge CLK) disable iff (!rst_n)
        cmd_start |-> !busy);

endmodule

/* verilog/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic           CLK,
    input  logic           rst_n,
    input  logic           f_req,
    input  mem_pkg::addr_t f_addr,
    input  logic           d_req,
    input  logic           d_we,
    input  mem_pkg::addr_t d_addr,
    input  mem_pkg::word_t d_wdata,
    input  logic           mem_ack,
    input  mem_pkg::word_t mem_rdata,
    output logic           f_ack,
    output mem_pkg::word_t f_rdata,
    output logic           d_ack,
    output mem_pkg::word_t d_rdata,
    output logic           mem_req,
    output logic           mem_we,
    output mem_pkg::addr_t mem_addr,
    output mem_pkg::word_t mem_wdata
);

    typedef enum logic [1:0] {
        IDLE,
        GRANT_F,
        GRANT_D
    } arb_state_t;

    arb_state_t state;
    logic       last_d;
    logic       owner_req;

    // Request of whoever holds the bus
    assign owner_req = (state == GRANT_F) ? f_req :
                       (state == GRANT_D) ? d_req : 1'b0;

    // Ack goes only to the owner, read data to both
    assign f_ack   = (state == GRANT_F) && mem_ack;
    assign d_ack   = (state == GRANT_D) && mem_ack;
    assign f_rdata = mem_rdata;
    assign d_rdata = mem_rdata;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            last_d  <= 1'b1;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // On a tie the master that did not go last wins
                    if (f_req && (!d_req || last_d)) begin
                        state  <= GRANT_F;
                        last_d <= 1'b0;
                    end else if (d_req) begin
                        state  <= GRANT_D;
                        last_d <= 1'b1;
                    end
                end
                default: begin
                    mem_req <= owner_req;
                    mem_we  <= (state == GRANT_D) && d_we;
                    // Release once every phase is back to zero
                    if (!owner_req && !mem_req && !mem_ack) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Owner address registered in step with mem_req
    always_ff @(posedge CLK) begin
        mem_addr  <= (state == GRANT_D) ? d_addr : f_addr;
        mem_wdata <= d_wdata;
    end

    // Address held for the whole request
    a_addr_stable: assert property (@(posedge CLK) disable iff (!rst_n)
        mem_req && $past(mem_req) |-> $stable(mem_addr));

    // Ack must already be low in the cycle req rises
    a_no_early_req: assert property (@(posedge CLK) disable iff (!rst_n)
        $rose(mem_req) |-> !$past(mem_ack));

endmodule

/* verilog/riscv_core.sv */
`timescale 1ns/1ps

module riscv_core #(
    parameter mem_pkg::addr_t RESET_PC = '0
) (
    input  logic           CLK,
    input  logic           rst_n,
    input  mem_pkg::word_t instr,
    input  logic           instr_valid,
    input  logic           done,
    input  mem_pkg::word_t load_data,
    output mem_pkg::addr_t pc,
    output logic           redirect,
    output logic           instr_take,
    output logic           cmd_start,
    output logic           cmd_we,
    output mem_pkg::addr_t cmd_addr,
    output mem_pkg::word_t cmd_wdata,
    output logic           halted
);

    riscv_pkg::core_state_t state;

    // x1..x31, x0 reads as zero
    mem_pkg::word_t regs [1:31];

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    riscv_pkg::reg_idx_t rd;
    riscv_pkg::reg_idx_t rs1;
    riscv_pkg::reg_idx_t rs2;
    riscv_pkg::reg_idx_t load_rd;
    mem_pkg::word_t      rs1_val;
    mem_pkg::word_t      rs2_val;
    mem_pkg::word_t      imm_i;
    mem_pkg::word_t      imm_s;
    mem_pkg::word_t      imm_b;
    mem_pkg::word_t      imm_u;
    mem_pkg::word_t      alu_res;
    mem_pkg::addr_t      pc_next;
    logic                is_load;
    logic                is_store;
    logic                writes_rd;
    logic                br_taken;
    logic                rf_we;
    riscv_pkg::reg_idx_t rf_waddr;
    mem_pkg::word_t      rf_wdata;

    // Field split
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Immediates, sign extended
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    assign is_load   = (opcode == riscv_pkg::OP_LOAD);
    assign is_store  = (opcode == riscv_pkg::OP_STORE);
    assign writes_rd = (opcode == riscv_pkg::OP_IMM) || (opcode == riscv_pkg::OP_REG) ||
                       (opcode == riscv_pkg::OP_LUI);

    // ALU; bit 30 selects SUB
    always_comb begin
        case (opcode)
            riscv_pkg::OP_REG: alu_res = instr[30] ? rs1_val - rs2_val : rs1_val + rs2_val;
            riscv_pkg::OP_LUI: alu_res = imm_u;
            default:           alu_res = rs1_val + imm_i;
        endcase
    end

    // Branch resolution
    assign br_taken = (opcode == riscv_pkg::OP_BRANCH) &&
                      (((funct3 == riscv_pkg::F3_BEQ) && (rs1_val == rs2_val)) ||
                       ((funct3 == riscv_pkg::F3_BNE) && (rs1_val != rs2_val)));
    assign pc_next = br_taken ? pc + imm_b : pc + 32'd4;

    // One instruction per buffer fill, only in EXEC
    assign instr_take = (state == riscv_pkg::EXEC) && instr_valid;
    assign redirect   = instr_take && br_taken;
    assign halted     = (state == riscv_pkg::HALT);

    // Memory command
    assign cmd_start = instr_take && (is_load || is_store);
    assign cmd_we    = is_store;
    assign cmd_addr  = rs1_val + (is_store ? imm_s : imm_i);
    assign cmd_wdata = rs2_val;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= riscv_pkg::EXEC;
            pc    <= RESET_PC;
        end else begin
            case (state)
                riscv_pkg::EXEC: begin
                    if (instr_take) begin
                        pc <= pc_next;
                        if (is_load || is_store) begin
                            state <= riscv_pkg::WAIT_MEM;
                        end else if (opcode == riscv_pkg::OP_SYSTEM) begin
                            state <= riscv_pkg::HALT;
                        end
                    end
                end
                riscv_pkg::WAIT_MEM: begin
                    if (done) begin
                        state <= riscv_pkg::EXEC;
                    end
                end
                default: begin
                    // Stays halted until reset
                    state <= riscv_pkg::HALT;
                end
            endcase
        end
    end

    // Load target; a store parks it on x0 so done writes nothing
    always_ff @(posedge CLK) begin
        if (cmd_start) begin
            load_rd <= is_store ? '0 : rd;
        end
    end

    // Single write port, load return or ALU result
    always_comb begin
        rf_we    = 1'b0;
        rf_waddr = rd;
        rf_wdata = alu_res;
        if ((state == riscv_pkg::WAIT_MEM) && done) begin
            rf_we    = 1'b1;
            rf_waddr = load_rd;
            rf_wdata = load_data;
        end else if (instr_take && writes_rd) begin
            rf_we = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (rf_we && (rf_waddr != '0)) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

endmodule

/* verilog/riscv_top.sv */
`timescale 1ns/1ps

module riscv_top #(
    parameter mem_pkg::addr_t RESET_PC = '0
) (
    input  logic           CLK,
    input  logic           rst_n,
    input  logic           mem_ack,
    input  mem_pkg::word_t mem_rdata,
    output logic           mem_req,
    output logic           mem_we,
    output mem_pkg::addr_t mem_addr,
    output mem_pkg::word_t mem_wdata,
    output logic           halted
);

    // Core to fetcher
    mem_pkg::addr_t pc;
    logic           redirect;
    logic           instr_take;
    mem_pkg::word_t instr;
    logic           instr_valid;

    // Core to lsu
    logic           cmd_start;
    logic           cmd_we;
    mem_pkg::addr_t cmd_addr;
    mem_pkg::word_t cmd_wdata;
    logic           done;
    mem_pkg::word_t load_data;

    // Masters to arbiter
    logic           f_req;
    logic           f_ack;
    mem_pkg::addr_t f_addr;
    mem_pkg::word_t f_rdata;
    logic           d_req;
    logic           d_ack;
    logic           d_we;
    mem_pkg::addr_t d_addr;
    mem_pkg::word_t d_wdata;
    mem_pkg::word_t d_rdata;

    riscv_core #(
        .RESET_PC(RESET_PC)
    ) core_i (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .instr      (instr),
        .instr_valid(instr_valid),
        .done       (done),
        .load_data  (load_data),
        .pc         (pc),
        .redirect   (redirect),
        .instr_take (instr_take),
        .cmd_start  (cmd_start),
        .cmd_we     (cmd_we),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .halted     (halted)
    );

    fetcher fetcher_i (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .pc         (pc),
        .redirect   (redirect),
        .instr_take (instr_take),
        .f_ack      (f_ack),
        .f_rdata    (f_rdata),
        .instr      (instr),
        .instr_valid(instr_valid),
        .f_req      (f_req),
        .f_addr     (f_addr)
    );

    lsu lsu_i (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .cmd_start(cmd_start),
        .cmd_we   (cmd_we),
        .cmd_addr (cmd_addr),
        .cmd_wdata(cmd_wdata),
        .d_ack    (d_ack),
        .d_rdata  (d_rdata),
        .done     (done),
        .load_data(load_data),
        .d_req    (d_req),
        .d_we     (d_we),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata)
    );

    mem_arbiter arbiter_i (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .f_req    (f_req),
        .f_addr   (f_addr),
        .d_req    (d_req),
        .d_we     (d_we),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .mem_ack  (mem_ack),
        .mem_rdata(mem_rdata),
        .f_ack    (f_ack),
        .f_rdata  (f_rdata),
        .d_ack    (d_ack),
        .d_rdata  (d_rdata),
        .mem_req  (mem_req),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata)
    );

endmodule

/* testbench/tb_riscv_top.sv */
`timescale 1ns/1ps

module tb_riscv_top;

    localparam mem_pkg::addr_t RESET_PC = 32'h0000_0000;

    // Run limit from program length, bus transactions and worst handshake
    localparam int INSTR_BUDGET   = 40;
    localparam int TXN_PER_INSTR  = 4;
    localparam int CYCLES_PER_TXN = 16;
    localparam int MAX_CYCLES     = INSTR_BUDGET * TXN_PER_INSTR * CYCLES_PER_TXN + 1440;

    logic           CLK = 1'b0;
    logic           rst_n;
    logic           mem_ack;
    mem_pkg::word_t mem_rdata;
    logic           mem_req;
    logic           mem_we;
    mem_pkg::addr_t mem_addr;
    mem_pkg::word_t mem_wdata;
    logic           halted;

    // Sparse memory, program image plus stored data
    mem_pkg::word_t image [mem_pkg::addr_t];
    mem_pkg::addr_t expected_addr [$];
    mem_pkg::word_t expected_data [$];
    int             store_idx = 0;
    logic           first_request = 1'b1;
    integer         seed = 32'hb4ff;
    int             cycle_count = 0;
    int             cycles_after_reset = 0;
    logic           prev_req = 1'b0;
    logic           prev_ack = 1'b0;
    mem_pkg::addr_t prev_addr = '0;

    riscv_top #(
        .RESET_PC(RESET_PC)
    ) UUT (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .mem_ack  (mem_ack),
        .mem_rdata(mem_rdata),
        .mem_req  (mem_req),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .halted   (halted)
    );

    // 40 ns period
    always #20 CLK = ~CLK;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string sig, input mem_pkg::word_t exp,
                                   input mem_pkg::word_t act);
        abort_run($sformatf("ERROR time=%0t %s expected %h actual %h", $time, sig, exp, act));
    endtask

    // P lines fill memory, S lines queue the expected stores in order
    task automatic load_golden();
        integer      fd;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] d;
        int          fields;
        fd = $fopen("testbench/program_golden.txt", "r");
        assert (fd != 0) else abort_run("Cannot open testbench/program_golden.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#") continue;
            fields = $sscanf(line, "%c %h %h", kind, a, d);
            if (fields != 3) continue;
            if (kind == "P") begin
                image[a] = d;
            end else if (kind == "S") begin
                expected_addr.push_back(a);
                expected_data.push_back(d);
            end else begin
                abort_run($sformatf("Unknown record type in golden file: %s", line));
            end
        end
        $fclose(fd);
        assert (expected_addr.size() > 0) else abort_run("Golden file lists no stores");
    endtask

    // 0 to 3 cycles, stays on the 1 ns drive offset
    task automatic wait_random_cycles();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic check_store(input mem_pkg::addr_t addr, input mem_pkg::word_t data);
        assert (store_idx < expected_addr.size())
            else abort_run($sformatf("Store to %h at %0t is beyond the expected list",
                                     addr, $time));
        assert (addr == expected_addr[store_idx])
            else report_mismatch("mem_addr", expected_addr[store_idx], addr);
        assert (data == expected_data[store_idx])
            else report_mismatch("mem_wdata", expected_data[store_idx], data);
        image[addr] = data;
        store_idx++;
    endtask

    // One full four-phase transaction on the memory side
    task automatic serve_request();
        mem_pkg::addr_t addr;
        logic           we;
        mem_pkg::word_t wdata;
        mem_pkg::word_t rdata;
        addr  = mem_addr;
        we    = mem_we;
        wdata = mem_wdata;
        rdata = '0;
        if (first_request) begin
            assert (!we) else abort_run("First bus transaction after reset is a write");
            assert (addr == RESET_PC) else report_mismatch("mem_addr", RESET_PC, addr);
        end
        first_request = 1'b0;
        if (we) begin
            check_store(addr, wdata);
        end else begin
            assert (image.exists(addr))
                else abort_run($sformatf("Read from unmapped address %h at %0t", addr, $time));
            rdata = image[addr];
        end
        wait_random_cycles();
        mem_rdata = rdata;
        mem_ack   = 1'b1;
        // Master drops req after seeing ack
        while (mem_req) begin
            @(posedge CLK);
            #1;
        end
        wait_random_cycles();
        mem_ack = 1'b0;
    endtask

    // Memory model, looks for a fresh request each cycle
    always begin
        @(posedge CLK);
        #1;
        if (rst_n && mem_req && !mem_ack) begin
            serve_request();
        end
    end

    // Bus protocol watch, halfway through each cycle
    always @(negedge CLK) begin
        if (!rst_n || cycles_after_reset < 2) begin
            assert (!mem_req) else abort_run("mem_req high during or right after reset");
        end
        if (mem_req && prev_req) begin
            assert (mem_addr == prev_addr) else report_mismatch("mem_addr", prev_addr, mem_addr);
        end
        if (mem_req && !prev_req) begin
            assert (!prev_ack) else abort_run("mem_req rose while mem_ack was still high");
        end
        prev_req  = mem_req;
        prev_ack  = mem_ack;
        prev_addr = mem_addr;
        if (rst_n) cycles_after_reset++;
    end

    // Watchdog
    always @(posedge CLK) begin
        cycle_count++;
        assert (cycle_count < MAX_CYCLES)
            else abort_run($sformatf("Timeout, core not halted after %0d cycles", MAX_CYCLES));
    end

    initial begin
        rst_n     = 1'b0;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        load_golden();
        repeat (10) @(posedge CLK);
        #1 rst_n = 1'b1;
        // halted sampled mid-cycle, away from the register update
        while (!halted) @(negedge CLK);
        assert (store_idx == expected_addr.size())
            else abort_run($sformatf("Halted after %0d of %0d expected stores",
                                     store_idx, expected_addr.size()));
        // Bus must stay quiet once halted
        repeat (20) begin
            @(negedge CLK);
            assert (halted) else abort_run("halted dropped after EBREAK");
            assert (!mem_req) else abort_run("mem_req raised after halt");
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* testbench/program_golden.txt */
# P <address> <word>   program image, one instruction per word
# S <address> <data>   expected stores, in bus order
P 00000000 10000093
P 00000004 00500113
P 00000008 FFD00193
P 0000000C 00310233
P 00000010 403102B3
P 00000014 12345337
P 00000018 0040A023
P 0000001C 0050A223
P 00000020 0060A423
P 00000024 0040A383
P 00000028 00638433
P 0000002C 0080A623
P 00000030 00310463
P 00000034 0020A823
P 00000038 00311463
P 0000003C 0030AA23
P 00000040 00420463
P 00000044 0030AC23
P 00000048 00529463
P 0000004C 0030AE23
P 00000050 00100073
# ALU results, then load plus add, then branch marked stores
S 00000100 00000002
S 00000104 00000008
S 00000108 12345000
S 0000010C 12345008
S 00000110 00000005
S 0000011C FFFFFFFD

/* filelist.f */
verilog/mem_pkg.sv
verilog/riscv_pkg.sv
verilog/fetcher.sv
verilog/lsu.sv
verilog/mem_arbiter.sv
verilog/riscv_core.sv
verilog/riscv_top.sv
testbench/tb_riscv_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, decide the result from the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module tb_riscv_top \
    -f filelist.f -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
